/* mmu_pkg.sv */
// Shared types for the reduced MMU.
// The cache page number is the low 14 bits of a PPN, so the cache tag
// logic truncates the PPN when it stores or compares a tag.
// All command strobes in mmu_cmd_t are active high and one cycle wide.
`default_nettype none

package mmu_pkg;

  typedef logic [10:0] la_t;      // Logical page number
  typedef logic [10:0] ca_t;      // Cache index
  typedef logic [15:0] ppn_t;     // Physical page number
  typedef logic [13:0] cpn_t;     // Cache page number, PPN[13:0]
  typedef logic [15:0] pt_word_t; // Page-table word

  // One page table entry
  typedef struct packed {
    ppn_t     ppn;
    pt_word_t pt;
  } pt_entry_t;

  // Registered command for one cycle
  typedef struct packed {
    logic        xlate;    // Translate la
    logic        wmap;     // Write page table entry
    logic        cwr;      // Cache tag fill
    logic        cclr;     // Start cache clear
    logic        lcs;      // Load CSR from idb
    logic        rd_pt;    // PT word onto IDB
    logic        rd_ppn;   // PPN onto IDB
    logic        rd_csr;   // CSR onto IDB
    logic        fmiss;    // Forced miss level
    la_t         la;
    ca_t         ca;
    logic [15:0] idb;
    pt_entry_t   wr_entry; // Entry for wmap
  } mmu_cmd_t;

  // Translation result, entry and ca held until next translation
  typedef struct packed {
    logic      valid;      // One cycle per translation
    pt_entry_t entry;
    ca_t       ca;
  } xlate_t;

  // Cache clear sweep
  typedef enum logic {
    CLR_IDLE  = 1'b0,
    CLR_SWEEP = 1'b1
  } clr_state_t;

endpackage

`default_nettype wire

/* mmu_bus_decode.sv */
// Input stage of the MMU.
// Strobes are active low and must be one sysclk wide; there is no
// handshake and no back-pressure, so a strobe held low for more cycles
// issues the command again on every cycle.
// Every field is captured on each edge, not only when a strobe is low.
`timescale 1ns/10ps
`default_nettype none

module mmu_bus_decode (
  input  wire                  sysclk,   // System clock
  input  wire                  arst_n,   // Async reset, active low

  input  wire                  xlate_n,  // Translate request
  input  wire                  wmap_n,   // Page table write
  input  wire                  cwr_n,    // Cache tag fill
  input  wire                  cclr_n,   // Cache clear
  input  wire                  lcs_n,    // Load CSR
  input  wire                  epti_n,   // Read PT word
  input  wire                  eipl_n,   // Read PPN
  input  wire                  ecsr_n,   // Read CSR
  input  wire                  fmiss,    // Force miss, level

  input  wire mmu_pkg::la_t     la,
  input  wire mmu_pkg::ca_t     ca,
  input  wire mmu_pkg::ppn_t    ppn_in,
  input  wire mmu_pkg::pt_word_t pt_in,
  input  wire [15:0]           idb_in,

  output mmu_pkg::mmu_cmd_t     cmd
);

  import mmu_pkg::*;

  mmu_cmd_t cmd_d; // Unregistered command

  always_comb begin
    cmd_d.xlate       = ~xlate_n; // Active-high pulses
    cmd_d.wmap        = ~wmap_n;
    cmd_d.cwr         = ~cwr_n;
    cmd_d.cclr        = ~cclr_n;
    cmd_d.lcs         = ~lcs_n;
    cmd_d.rd_pt       = ~epti_n;
    cmd_d.rd_ppn      = ~eipl_n;
    cmd_d.rd_csr      = ~ecsr_n;
    cmd_d.fmiss       = fmiss;
    cmd_d.la          = la;
    cmd_d.ca          = ca;
    cmd_d.idb         = idb_in;
    cmd_d.wr_entry.ppn = ppn_in;
    cmd_d.wr_entry.pt  = pt_in;
  end

  // Single stage, common time base for all blocks
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      cmd <= '0; // No command pending
    end else begin
      cmd <= cmd_d;
    end
  end

endmodule

`default_nettype wire

/* mmu_page_table.sv */
// Page table of the MMU, one pt_entry_t per logical page.
// Read is two stages deep: RAM output register, then the xr register.
// A write and a translation of the same page in one cycle return the
// old entry. PT_DEPTH must be a power of two, at most 2048.
// RAM contents are undefined until written.
`timescale 1ns/10ps
`default_nettype none

module mmu_page_table #(
  parameter int PT_DEPTH = 2048
) (
  input  wire                   sysclk,
  input  wire                   arst_n,
  input  wire mmu_pkg::mmu_cmd_t cmd,
  output mmu_pkg::xlate_t        xr
);

  import mmu_pkg::*;

  localparam int PT_AW = $clog2(PT_DEPTH);

  pt_entry_t        mem [PT_DEPTH]; // Block RAM
  pt_entry_t        rd_entry;       // RAM output register
  ca_t              rd_ca;          // ca travelling with the read
  logic             rd_valid;       // Read issued last cycle
  logic [PT_AW-1:0] pt_idx;

  assign pt_idx = cmd.la[PT_AW-1:0];

  // RAM port, write at E+1, read at E+1
  always_ff @(posedge sysclk) begin
    if (cmd.wmap) begin
      mem[pt_idx] <= cmd.wr_entry;
    end
    if (cmd.xlate) begin
      rd_entry <= mem[pt_idx];
      rd_ca    <= cmd.ca; // Index for the tag lookup
    end
  end

  // Result register at E+2
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
      xr       <= '0; // ppn_out and pt_out read zero
    end else begin
      rd_valid <= cmd.xlate;
      xr.valid <= rd_valid; // One cycle pulse
      if (rd_valid) begin
        xr.entry <= rd_entry; // Held until next translation
        xr.ca    <= rd_ca;
      end
    end
  end

endmodule

`default_nettype wire

/* mmu_cache_tag.sv */
// Direct-mapped cache tag store with hit compare, fill and clear sweep.
// A clear takes CACHE_DEPTH cycles; cwr and cclr given during it are
// dropped and no hit is reported. Fills store the cpn of the last
// translation result. CACHE_DEPTH must be a power of two, at most 2048.
// Valid bits are reset, tag contents are not.
`timescale 1ns/10ps
`default_nettype none

module mmu_cache_tag #(
  parameter int CACHE_DEPTH = 2048
) (
  input  wire                   sysclk,
  input  wire                   arst_n,
  input  wire mmu_pkg::mmu_cmd_t cmd,
  input  wire mmu_pkg::xlate_t   xr,
  input  wire                   con,      // Cache on
  output logic                  hit,
  output logic                  clr_busy
);

  import mmu_pkg::*;

  localparam int               CA_AW    = $clog2(CACHE_DEPTH);
  localparam logic [CA_AW-1:0] CLR_LAST = CA_AW'(CACHE_DEPTH - 1);

  cpn_t                   tag_mem [CACHE_DEPTH]; // Stored cpn per index
  logic [CACHE_DEPTH-1:0] tag_valid;
  clr_state_t             state;
  logic [CA_AW-1:0]       clr_idx;               // Sweep pointer
  logic [1:0]             fmiss_pipe;            // fmiss aligned to xr
  logic [CA_AW-1:0]       fill_idx;
  logic [CA_AW-1:0]       look_idx;
  logic                   idle;
  logic                   fill;
  logic                   clr_start;
  logic                   con_nxt;
  logic                   tag_match;
  logic                   hit_nxt;

  assign idle      = (state == CLR_IDLE);
  assign clr_busy  = (state == CLR_SWEEP);
  assign fill_idx  = cmd.ca[CA_AW-1:0];
  assign look_idx  = xr.ca[CA_AW-1:0];
  assign fill      = cmd.cwr & idle;  // Dropped during sweep
  assign clr_start = cmd.cclr & idle; // Dropped during sweep

  // con as it will be after this edge, a CSR load may clear it now
  assign con_nxt = cmd.lcs ? cmd.idb[0] : con;

  assign tag_match = tag_valid[look_idx] &&
                     (tag_mem[look_idx] == cpn_t'(xr.entry.ppn));

  // No hit while sweeping or when the sweep starts at this edge
  assign hit_nxt = xr.valid & tag_match & con & con_nxt &
                   ~fmiss_pipe[1] & idle & ~clr_start;

  // Tag RAM, no reset
  always_ff @(posedge sysclk) begin
    if (fill) begin
      tag_mem[fill_idx] <= cpn_t'(xr.entry.ppn); // Low 14 bits of ppn_out
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= CLR_IDLE;
      clr_idx    <= '0;
      tag_valid  <= '0; // All entries invalid
      fmiss_pipe <= '0;
      hit        <= 1'b0;
    end else begin
      fmiss_pipe <= {fmiss_pipe[0], cmd.fmiss};
      hit        <= hit_nxt; // High at E+3
      case (state)
        CLR_IDLE: begin
          if (fill) begin
            tag_valid[fill_idx] <= 1'b1;
          end
          if (clr_start) begin
            state   <= CLR_SWEEP;
            clr_idx <= '0;
          end
        end
        CLR_SWEEP: begin
          tag_valid[clr_idx] <= 1'b0; // One index per cycle
          clr_idx            <= clr_idx + 1'b1;
          if (clr_idx == CLR_LAST) begin
            state <= CLR_IDLE;
          end
        end
        default: state <= CLR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* mmu_csr.sv */
// Control and status register of the MMU.
// Only the cache-on and stop bits are kept; bits 3:2 read as zero.
// A load takes idb bits 1:0 one cycle after lcs_n was sampled.
`timescale 1ns/10ps
`default_nettype none

module mmu_csr (
  input  wire                   sysclk,
  input  wire                   arst_n,
  input  wire mmu_pkg::mmu_cmd_t cmd,
  output logic                  con,      // Cache on
  output logic                  stp,      // Stop
  output logic [3:0]            csr_word  // Read-back value
);

  // Load from the registered IDB value
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      con <= 1'b0; // Cache off after reset
      stp <= 1'b0;
    end else if (cmd.lcs) begin
      con <= cmd.idb[0];
      stp <= cmd.idb[1];
    end
  end

  assign csr_word = {2'b00, stp, con}; // Unused bits zero

endmodule

`default_nettype wire

/* mmu_idb_mux.sv */
// IDB read-back stage of the MMU.
// Read strobes are delayed one stage, the selected sources are ORed and
// registered, so idb_out is valid for one cycle after edge E+2.
// PT and PPN read back the last translation result.
`timescale 1ns/10ps
`default_nettype none

module mmu_idb_mux (
  input  wire                   sysclk,
  input  wire                   arst_n,
  input  wire mmu_pkg::mmu_cmd_t cmd,
  input  wire mmu_pkg::xlate_t   xr,
  input  wire [3:0]             csr_word,
  output logic [15:0]           idb_out
);

  import mmu_pkg::*;

  logic        rd_pt_d;  // Delayed epti
  logic        rd_ppn_d; // Delayed eipl
  logic        rd_csr_d; // Delayed ecsr
  pt_word_t    pt_src;
  ppn_t        ppn_src;
  logic [15:0] csr_src;

  assign pt_src  = rd_pt_d  ? xr.entry.pt  : '0;
  assign ppn_src = rd_ppn_d ? xr.entry.ppn : '0;
  assign csr_src = rd_csr_d ? {12'h000, csr_word} : '0; // Zero extended

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      rd_pt_d  <= 1'b0;
      rd_ppn_d <= 1'b0;
      rd_csr_d <= 1'b0;
      idb_out  <= '0;
    end else begin
      rd_pt_d  <= cmd.rd_pt;
      rd_ppn_d <= cmd.rd_ppn;
      rd_csr_d <= cmd.rd_csr;
      idb_out  <= pt_src | ppn_src | csr_src; // Wired-OR bus, zero when idle
    end
  end

endmodule

`default_nettype wire

/* mmu_top.sv */
// Top level of the reduced MMU.
// No cache data RAM, shadow map, interrupt mask or console logic.
// Outputs are plain drivers; nothing is tri-stated.
// PT_DEPTH and CACHE_DEPTH must be powers of two, at most 2048.
`timescale 1ns/10ps
`default_nettype none

module mmu_top #(
  parameter int PT_DEPTH    = 2048,
  parameter int CACHE_DEPTH = 2048
) (
  input  wire                   sysclk,    // System clock
  input  wire                   arst_n,    // Async reset, active low

  input  wire                   xlate_n,
  input  wire                   wmap_n,
  input  wire                   cwr_n,
  input  wire                   cclr_n,
  input  wire                   lcs_n,
  input  wire                   epti_n,
  input  wire                   eipl_n,
  input  wire                   ecsr_n,
  input  wire                   fmiss,

  input  wire mmu_pkg::la_t      la_20_10,
  input  wire mmu_pkg::ca_t      ca_10_0,
  input  wire mmu_pkg::ppn_t     ppn_in,
  input  wire mmu_pkg::pt_word_t pt_in,
  input  wire [15:0]            idb_in,

  output mmu_pkg::ppn_t          ppn_out,   // Last translated PPN
  output mmu_pkg::pt_word_t      pt_out,    // Last translated PT word
  output logic [15:0]           idb_out,
  output logic                  hit,
  output logic                  clr_busy,
  output logic                  led1,      // Cache enabled
  output logic                  bstp       // Bus stop
);

  import mmu_pkg::*;

  mmu_cmd_t   cmd;
  xlate_t     xr;
  logic       con;
  logic       stp;
  logic [3:0] csr_word;

  mmu_bus_decode decode_i (
    .sysclk (sysclk),  .arst_n (arst_n),
    .xlate_n(xlate_n), .wmap_n (wmap_n), .cwr_n  (cwr_n),  .cclr_n (cclr_n),
    .lcs_n  (lcs_n),   .epti_n (epti_n), .eipl_n (eipl_n), .ecsr_n (ecsr_n),
    .fmiss  (fmiss),   .la     (la_20_10), .ca   (ca_10_0),
    .ppn_in (ppn_in),  .pt_in  (pt_in),  .idb_in (idb_in), .cmd    (cmd)
  );

  mmu_page_table #(.PT_DEPTH(PT_DEPTH)) pt_i (
    .sysclk(sysclk), .arst_n(arst_n), .cmd(cmd), .xr(xr)
  );

  mmu_cache_tag #(.CACHE_DEPTH(CACHE_DEPTH)) tag_i (
    .sysclk  (sysclk), .arst_n(arst_n), .cmd(cmd), .xr(xr), .con(con),
    .hit     (hit),    .clr_busy(clr_busy)
  );

  mmu_csr csr_i (
    .sysclk(sysclk), .arst_n(arst_n), .cmd(cmd),
    .con   (con),    .stp   (stp),    .csr_word(csr_word)
  );

  mmu_idb_mux idb_i (
    .sysclk  (sysclk),   .arst_n(arst_n), .cmd(cmd), .xr(xr),
    .csr_word(csr_word), .idb_out(idb_out)
  );

  assign ppn_out = xr.entry.ppn;
  assign pt_out  = xr.entry.pt;
  assign led1    = con; // LED follows cache-on
  assign bstp    = stp;

endmodule

`default_nettype wire

/* mmu_properties.sv */
// Checks on the cache tag store, bound into every mmu_cache_tag.
// fail_cnt counts failed assertions and is read from the testbench.
`timescale 1ns/10ps
`default_nettype none

module mmu_properties (
  input wire sysclk,
  input wire arst_n,
  input wire cclr,      // Registered clear command
  input wire con,       // Cache on
  input wire hit,
  input wire clr_busy
);

  int unsigned fail_cnt = 0;

  // No hit while sweeping
  assert property (@(posedge sysclk) disable iff (!arst_n) clr_busy |-> !hit)
    else begin fail_cnt++; $error("hit high during cache clear"); end

  // No hit with the cache off
  assert property (@(posedge sysclk) disable iff (!arst_n) hit |-> con)
    else begin fail_cnt++; $error("hit high while con low"); end

  // Clear starts one cycle after an accepted command
  assert property (@(posedge sysclk) disable iff (!arst_n) (cclr && !clr_busy) |=> clr_busy)
    else begin fail_cnt++; $error("clr_busy late after cclr"); end

  assert property (@(posedge sysclk) disable iff (!arst_n) $rose(clr_busy) |-> $past(cclr))
    else begin fail_cnt++; $error("clr_busy rose without cclr"); end

endmodule

bind mmu_cache_tag mmu_properties props_i (
  .sysclk(sysclk), .arst_n(arst_n), .cclr(cmd.cclr), .con(con),
  .hit(hit), .clr_busy(clr_busy)
);

`default_nettype wire

/* tb_mmu.sv */
// Testbench for the reduced MMU with stimulus and expected values from mmu_vectors.txt.
// Each vector holds seven hex words op, la, ca, ppn, pt, idb and expected.
// Inputs change 2 ns after the rising edge and outputs are read on the falling edge.
// Stops at the first mismatch. Default PT_DEPTH and CACHE_DEPTH only.
`timescale 1ns/10ps
`default_nettype none

module tb_mmu;

  import mmu_pkg::*;

  localparam int         MAX_VEC = 40;
  localparam logic [7:0] M_XLATE = 8'h01; // Strobe mask bits
  localparam logic [7:0] M_WMAP  = 8'h02;
  localparam logic [7:0] M_CWR   = 8'h04;
  localparam logic [7:0] M_CCLR  = 8'h08;
  localparam logic [7:0] M_LCS   = 8'h10;

  logic        sysclk, arst_n;
  logic        xlate_n, wmap_n, cwr_n, cclr_n, lcs_n, epti_n, eipl_n, ecsr_n, fmiss;
  la_t         la_20_10;
  ca_t         ca_10_0;
  ppn_t        ppn_in, ppn_out;
  pt_word_t    pt_in, pt_out;
  logic [15:0] idb_in, idb_out;
  logic        hit, clr_busy, led1, bstp;
  logic [31:0] vec_mem [MAX_VEC*7]; // Seven words per vector
  ppn_t        exp_ppn [16];        // Expected results of a translation run
  pt_word_t    exp_pt  [16];
  la_t         hit_la;              // Last page that was expected to hit
  ca_t         hit_ca;

  mmu_top mmu_top_i (.*);

  always #20 sysclk = ~sysclk; // 40 ns period

  // Stop at the first failed assertion in the bound checker
  always @(negedge sysclk) begin
    if (mmu_top_i.tag_i.props_i.fail_cnt != 0) begin
      $display("An assertion on the cache tag store failed");
      $display(">>> FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic stop_with_message(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "Run stopped");
  endtask

  // One cycle of stimulus where a set mask bit pulls its strobe low
  task automatic drive_inputs(input logic [7:0] mask, input logic [31:0] f_la, f_ca,
                              f_ppn, f_pt, f_idb, input logic f_fmiss);
    @(posedge sysclk);
    #2;
    {ecsr_n, eipl_n, epti_n, lcs_n, cclr_n, cwr_n, wmap_n, xlate_n} = ~mask;
    la_20_10 = f_la[10:0];
    ca_10_0  = f_ca[10:0];
    ppn_in   = f_ppn[15:0];
    pt_in    = f_pt[15:0];
    idb_in   = f_idb[15:0];
    fmiss    = f_fmiss;
  endtask

  task automatic release_strobes();
    @(posedge sysclk);
    #2;
    {ecsr_n, eipl_n, epti_n, lcs_n, cclr_n, cwr_n, wmap_n, xlate_n} = 8'hff;
  endtask

  // Starts just after a release and lands on the falling edge after edge E+edges
  task automatic sample_after(input int edges);
    repeat (edges) @(posedge sysclk);
    @(negedge sysclk);
  endtask

  // Back-to-back translations with entry k read three cycles after its drive
  task automatic translate_seq(input logic [31:0] base, f_ca, input int n);
    int j;
    for (j = 0; j < n + 3; j++) begin
      if (j < n) drive_inputs(M_XLATE, base + j, f_ca, 32'h0, 32'h0, 32'h0, 1'b0);
      else release_strobes();
      @(negedge sysclk);
      if (j >= 3) begin
        check_value("ppn_out", exp_ppn[j-3], ppn_out);
        check_value("pt_out", exp_pt[j-3], pt_out);
      end
    end
  endtask

  task automatic run_vector(input int base);
    logic [31:0] op, v_la, v_ca, v_ppn, v_pt, v_idb, v_exp;
    int          count;
    int          k;
    op    = vec_mem[base];
    v_la  = vec_mem[base+1];
    v_ca  = vec_mem[base+2];
    v_ppn = vec_mem[base+3];
    v_pt  = vec_mem[base+4];
    v_idb = vec_mem[base+5];
    v_exp = vec_mem[base+6];
    case (op)
      1: begin // Page table write
        drive_inputs(M_WMAP, v_la, v_ca, v_ppn, v_pt, v_idb, 1'b0);
        release_strobes();
      end
      2: begin // Single translation with expected {ppn, pt}
        exp_ppn[0] = v_exp[31:16];
        exp_pt[0]  = v_exp[15:0];
        translate_seq(v_la, v_ca, 1);
      end
      3: begin // CSR load
        drive_inputs(M_LCS, v_la, v_ca, v_ppn, v_pt, v_idb, 1'b0);
        release_strobes();
        sample_after(1);
        check_value("{bstp, led1}", v_exp, {30'h0, bstp, led1});
      end
      4: begin // Read-back where idb bits 2:0 select ecsr, eipl and epti
        drive_inputs({v_idb[2:0], 5'h00}, v_la, v_ca, v_ppn, v_pt, v_idb, 1'b0);
        release_strobes();
        sample_after(2);
        check_value("idb_out", v_exp, {16'h0, idb_out});
      end
      5: begin // Tag fill from the held ppn_out
        drive_inputs(M_CWR, v_la, v_ca, v_ppn, v_pt, v_idb, 1'b0);
        release_strobes();
      end
      6: begin // Hit check with fmiss from idb bit 0 set a cycle early
        drive_inputs(8'h00, v_la, v_ca, v_ppn, v_pt, v_idb, v_idb[0]);
        drive_inputs(M_XLATE, v_la, v_ca, v_ppn, v_pt, v_idb, v_idb[0]);
        release_strobes();
        sample_after(3);
        check_value("hit", v_exp, {31'h0, hit});
        if (v_exp[0]) begin
          hit_la = v_la[10:0];
          hit_ca = v_ca[10:0];
        end
      end
      7: begin // Clear and translation of the last hit page in one cycle
        drive_inputs(M_CCLR | M_XLATE, hit_la, hit_ca, v_ppn, v_pt, v_idb, 1'b0);
        release_strobes();
        count = 0;
        @(negedge sysclk);
        while (!clr_busy) begin
          count++;
          if (count > 4) stop_with_message("Timeout, cache clear did not start");
          @(negedge sysclk);
        end
        count = 0;
        while (clr_busy) begin
          count++;
          if (count > 4096) stop_with_message("Timeout, cache clear did not finish");
          check_value("hit", 32'h0, {31'h0, hit}); // No hit during the sweep
          @(negedge sysclk);
        end
        check_value("clr_busy cycles", v_exp, count);
      end
      8: begin // Random entries from la onward with the count in idb
        for (k = 0; k < int'(v_idb[3:0]); k++) begin
          exp_ppn[k] = ppn_t'($urandom());
          exp_pt[k]  = pt_word_t'($urandom());
          drive_inputs(M_WMAP, v_la + k, v_ca, exp_ppn[k], exp_pt[k], 32'h0, 1'b0);
        end
        release_strobes();
        translate_seq(v_la, v_ca, int'(v_idb[3:0]));
      end
      default: stop_with_message("Unknown operation code in the vector file");
    endcase
  endtask

  initial begin
    int idx;
    void'($urandom(32'h7397_fd2d));
    sysclk = 1'b0;
    arst_n = 1'b0;
    {ecsr_n, eipl_n, epti_n, lcs_n, cclr_n, cwr_n, wmap_n, xlate_n} = 8'hff;
    fmiss    = 1'b0;
    la_20_10 = '0;
    ca_10_0  = '0;
    ppn_in   = '0;
    pt_in    = '0;
    idb_in   = '0;
    hit_la   = '0;
    hit_ca   = '0;
    $readmemh("mmu_vectors.txt", vec_mem);
    repeat (5) @(posedge sysclk); // Reset for 5 cycles
    #2 arst_n = 1'b1;
    idx = 0;
    while (idx < MAX_VEC && vec_mem[idx*7] !== 32'h0) begin // Op 0 ends the list
      run_vector(idx * 7);
      idx++;
    end
    if (mmu_top_i.tag_i.props_i.fail_cnt == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display(">>> FAIL");
      $fatal(1, "Assertion failures during the run");
    end
  end

endmodule

`default_nettype wire

/* mmu_vectors.txt */
// op la ca ppn pt idb expected, all hex, one operation per line
// op 1 wmap, 2 xlate, 3 csr load, 4 read, 5 fill, 6 hit, 7 clear, 8 random, 0 end
01 005 000 1234 a5a5 0000 00000000
01 006 000 c234 0f0f 0000 00000000
01 007 000 1235 3c3c 0000 00000000
01 008 000 5234 7777 0000 00000000
02 005 010 0000 0000 0000 1234a5a5
02 007 010 0000 0000 0000 12353c3c
08 100 000 0000 0000 0006 00000000
03 000 000 0000 0000 0003 00000003
04 000 000 0000 0000 0004 00000003
03 000 000 0000 0000 0001 00000001
04 000 000 0000 0000 0004 00000001
02 005 010 0000 0000 0000 1234a5a5
05 000 010 0000 0000 0000 00000000
06 005 010 0000 0000 0000 00000001
06 008 010 0000 0000 0000 00000001
06 006 010 0000 0000 0000 00000000
06 005 011 0000 0000 0000 00000000
06 005 010 0000 0000 0001 00000000
03 000 000 0000 0000 0000 00000000
06 005 010 0000 0000 0000 00000000
03 000 000 0000 0000 0001 00000001
06 005 010 0000 0000 0000 00000001
07 000 000 0000 0000 0000 00000800
06 005 010 0000 0000 0000 00000000
02 007 010 0000 0000 0000 12353c3c
04 000 000 0000 0000 0001 00003c3c
04 000 000 0000 0000 0002 00001235
04 000 000 0000 0000 0003 00003e3d
04 000 000 0000 0000 0000 00000000
00 000 000 0000 0000 0000 00000000

/* sources.f */
mmu_pkg.sv
mmu_bus_decode.sv
mmu_page_table.sv
mmu_cache_tag.sv
mmu_csr.sv
mmu_idb_mux.sv
mmu_top.sv
mmu_properties.sv
tb_mmu.sv
